//--- include/crtc_settings.svh
`ifndef CRTC_SETTINGS_SVH
`define CRTC_SETTINGS_SVH

// Frame store address width in bits, 16K bytes
`define CRTC_ADR_WIDTH 14

// Width of one frame store byte and of the processor data bus
`define CRTC_DATA_WIDTH 8

// Pixels shifted out for each character
`define CRTC_CHAR_PIXELS 8

`endif

//--- design/crtcPkg.sv
`include "crtc_settings.svh"

package crtcPkg;

	typedef logic [7:0] charCount_t;
	typedef logic [6:0] rowCount_t;
	typedef logic [4:0] scanLine_t;
	typedef logic [`CRTC_ADR_WIDTH-1:0] memAdr_t;

	typedef enum logic [1:0] {hDisplay, hFront, hPulse, hBack} hState_t;
	typedef enum logic [1:0] {vDisplay, vFront, vPulse, vBack} vState_t;

	// Programmed register file, R8 is not kept
	typedef struct packed {
		charCount_t horzTotal;
		charCount_t horzDisplayed;
		charCount_t horzSyncPos;
		logic [3:0] hSyncWidth;
		logic [3:0] vSyncWidth;
		rowCount_t vertTotal;
		scanLine_t vertTotalAdj;
		rowCount_t vertDisplayed;
		rowCount_t vertSyncPos;
		scanLine_t maxScanLine;
		scanLine_t cursorStart;
		scanLine_t cursorEnd;
		logic [1:0] blinkMode;
		memAdr_t startAdr;
		memAdr_t cursorAdr;
	} crtcConfig_t;

	// One character slot from the timing generator
	typedef struct packed {
		memAdr_t adr;
		scanLine_t row;
		logic disEn;
		logic cursor;
	} videoBeat_t;

	// Fetched byte with its flags
	typedef struct packed {
		logic [`CRTC_DATA_WIDTH-1:0] data;
		logic disEn;
		logic cursor;
	} fetchBeat_t;

endpackage

//--- design/crtcRegisters.sv
`include "crtc_settings.svh"

module crtcRegisters (
	input  logic CLK,
	input  logic nRESET,
	input  logic cs,
	input  logic rnw,
	input  logic a0,
	input  logic [`CRTC_DATA_WIDTH-1:0] dataIn,
	output logic [`CRTC_DATA_WIDTH-1:0] dataOut,
	output crtcPkg::crtcConfig_t cfg,
	output logic hRestart,
	output logic vRestart
);

	logic [4:0] regSel;
	logic regWrite;
	logic dataWrite;

	assign regWrite = cs && !rnw;
	assign dataWrite = regWrite && a0;

	// Address register on a0 low, selected register on a0 high
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			regSel <= '0;
			cfg <= '0;
		end else if (regWrite) begin
			if (!a0) begin
				regSel <= dataIn[4:0];
			end else begin
				case (regSel)
					5'd0: cfg.horzTotal <= dataIn;
					5'd1: cfg.horzDisplayed <= dataIn;
					5'd2: cfg.horzSyncPos <= dataIn;
					5'd3: begin
						cfg.vSyncWidth <= dataIn[7:4];
						cfg.hSyncWidth <= dataIn[3:0];
					end
					5'd4: cfg.vertTotal <= dataIn[6:0];
					5'd5: cfg.vertTotalAdj <= dataIn[4:0];
					5'd6: cfg.vertDisplayed <= dataIn[6:0];
					5'd7: cfg.vertSyncPos <= dataIn[6:0];
					5'd9: cfg.maxScanLine <= dataIn[4:0];
					5'd10: begin
						cfg.blinkMode <= dataIn[6:5];
						cfg.cursorStart <= dataIn[4:0];
					end
					5'd11: cfg.cursorEnd <= dataIn[4:0];
					5'd12: cfg.startAdr[13:8] <= dataIn[5:0];
					5'd13: cfg.startAdr[7:0] <= dataIn;
					5'd14: cfg.cursorAdr[13:8] <= dataIn[5:0];
					5'd15: cfg.cursorAdr[7:0] <= dataIn;
					default: ;
				endcase
			end
		end
	end

	// Cursor address readback, high byte on even select
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			dataOut <= '0;
		end else if (cs && rnw) begin
			if (regSel[0])
				dataOut <= cfg.cursorAdr[7:0];
			else
				dataOut <= {2'b00, cfg.cursorAdr[13:8]};
		end
	end

	// R0-R3 restart the line, R4-R7 the frame
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			hRestart <= 1'b0;
			vRestart <= 1'b0;
		end else begin
			hRestart <= dataWrite && (regSel[4:2] == 3'b000);
			vRestart <= dataWrite && (regSel[4:2] == 3'b001);
		end
	end

endmodule

//--- design/crtcTiming.sv
module crtcTiming (
	input  logic CLK,
	input  logic nRESET,
	input  logic charEn,
	input  crtcPkg::crtcConfig_t cfg,
	input  logic hRestart,
	input  logic vRestart,
	output crtcPkg::videoBeat_t beat,
	output logic hSync,
	output logic vSync
);

	import crtcPkg::*;

	hState_t hState;
	vState_t vState;
	charCount_t hCount;
	charCount_t nextH;
	rowCount_t rowCount;
	rowCount_t nextRow;
	scanLine_t scan;
	scanLine_t adjCount;
	logic [3:0] hPulseCount;
	logic [3:0] vPulseCount;
	logic inAdj;
	memAdr_t frameAdr;
	memAdr_t lineAdr;
	memAdr_t rowAdr;
	logic [5:0] blinkCount;
	logic hPending;
	logic vPending;
	logic hKick;
	logic vKick;
	logic newLine;
	logic endOfRow;
	logic lastRow;
	logic newRow;
	logic newFrame;
	logic displayOn;
	logic cursorVisible;
	logic cursorRow;

	assign hKick = hPending || hRestart;
	assign vKick = vPending || vRestart;
	assign nextH = hCount + 1'b1;
	assign nextRow = rowCount + 1'b1;
	assign newLine = (hCount == cfg.horzTotal) || hKick;
	assign endOfRow = scan == cfg.maxScanLine;
	assign lastRow = rowCount >= cfg.vertTotal;
	assign rowAdr = lineAdr + memAdr_t'(cfg.horzDisplayed);

	// Frame ends after the last row, or after the adjust lines if any
	always_comb begin
		newFrame = 1'b0;
		if (newLine) begin
			if (vKick)
				newFrame = 1'b1;
			else if (inAdj)
				newFrame = adjCount == cfg.vertTotalAdj;
			else
				newFrame = endOfRow && lastRow && (cfg.vertTotalAdj == '0);
		end
	end

	assign newRow = newLine && !newFrame && !inAdj && endOfRow && !lastRow;

	// Restart pulses are held until the character clock sees them
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			hPending <= 1'b0;
			vPending <= 1'b0;
		end else begin
			if (charEn)
				hPending <= 1'b0;
			else if (hRestart)
				hPending <= 1'b1;
			if (charEn && newLine)
				vPending <= 1'b0;
			else if (vRestart)
				vPending <= 1'b1;
		end
	end

	// Horizontal machine, one step per character
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			hCount <= '0;
			hState <= hDisplay;
			hPulseCount <= '0;
		end else if (charEn) begin
			if (newLine) begin
				hCount <= '0;
				hState <= hDisplay;
				hPulseCount <= '0;
			end else begin
				hCount <= nextH;
				case (hState)
					hDisplay: begin
						if (nextH == cfg.horzDisplayed)
							hState <= hFront;
					end
					hFront: begin
						if (nextH == cfg.horzSyncPos) begin
							hState <= (cfg.hSyncWidth != '0) ? hPulse : hBack;
							hPulseCount <= 4'd1;
						end
					end
					hPulse: begin
						if (hPulseCount == cfg.hSyncWidth)
							hState <= hBack;
						else
							hPulseCount <= hPulseCount + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// Vertical machine, one step per scan line
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			rowCount <= '0;
			scan <= '0;
			inAdj <= 1'b0;
			adjCount <= '0;
			vState <= vDisplay;
			vPulseCount <= '0;
			blinkCount <= '0;
		end else if (charEn && newLine) begin
			if (newFrame) begin
				rowCount <= '0;
				scan <= '0;
				inAdj <= 1'b0;
				adjCount <= '0;
				vState <= vDisplay;
				vPulseCount <= '0;
				blinkCount <= blinkCount + 1'b1;
			end else begin
				if (inAdj) begin
					adjCount <= adjCount + 1'b1;
					scan <= scan + 1'b1;
				end else if (endOfRow) begin
					scan <= '0;
					if (lastRow) begin
						// Extra scan lines after the last row
						inAdj <= 1'b1;
						adjCount <= 5'd1;
					end else begin
						rowCount <= nextRow;
					end
				end else begin
					scan <= scan + 1'b1;
				end
				case (vState)
					vDisplay: begin
						if (newRow && nextRow == cfg.vertDisplayed)
							vState <= vFront;
					end
					vFront: begin
						if (newRow && nextRow == cfg.vertSyncPos) begin
							vState <= (cfg.vSyncWidth != '0) ? vPulse : vBack;
							vPulseCount <= 4'd1;
						end
					end
					vPulse: begin
						if (vPulseCount == cfg.vSyncWidth)
							vState <= vBack;
						else
							vPulseCount <= vPulseCount + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// Each row starts horzDisplayed past the previous one
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			frameAdr <= '0;
			lineAdr <= '0;
		end else if (charEn) begin
			if (newFrame) begin
				frameAdr <= cfg.startAdr;
				lineAdr <= cfg.startAdr;
			end else if (newRow) begin
				frameAdr <= rowAdr;
				lineAdr <= rowAdr;
			end else if (newLine) begin
				frameAdr <= lineAdr;
			end else begin
				frameAdr <= frameAdr + 1'b1;
			end
		end
	end

	// Blink rates of 16 and 32 frames
	always_comb begin
		case (cfg.blinkMode)
			2'd0: cursorVisible = 1'b1;
			2'd1: cursorVisible = 1'b0;
			2'd2: cursorVisible = blinkCount[4];
			default: cursorVisible = blinkCount[5];
		endcase
	end

	assign cursorRow = (scan >= cfg.cursorStart) && (scan <= cfg.cursorEnd);
	assign displayOn = (hState == hDisplay) && (vState == vDisplay);

	always_comb begin
		beat.adr = frameAdr;
		beat.row = scan;
		beat.disEn = displayOn;
		beat.cursor = displayOn && cursorVisible && cursorRow && (frameAdr == cfg.cursorAdr);
	end

	assign hSync = hState == hPulse;
	assign vSync = vState == vPulse;

endmodule

//--- design/frameStore.sv
`include "crtc_settings.svh"

module frameStore (
	input  logic CLK,
	input  logic charEn,
	input  logic memWrite,
	input  crtcPkg::memAdr_t memAdr,
	input  logic [`CRTC_DATA_WIDTH-1:0] memData,
	input  crtcPkg::videoBeat_t beat,
	output crtcPkg::fetchBeat_t fetch
);

	localparam int depth = 1 << `CRTC_ADR_WIDTH;

	logic [`CRTC_DATA_WIDTH-1:0] mem [0:depth-1];

	// Processor side write port
	always_ff @(posedge CLK) begin
		if (memWrite)
			mem[memAdr] <= memData;
	end

	// Video side read, flags travel with the byte
	always_ff @(posedge CLK) begin
		if (charEn) begin
			fetch.data <= mem[beat.adr];
			fetch.disEn <= beat.disEn;
			fetch.cursor <= beat.cursor;
		end
	end

endmodule

//--- design/pixelShifter.sv
`include "crtc_settings.svh"

module pixelShifter (
	input  logic CLK,
	input  logic nRESET,
	input  logic charEn,
	input  crtcPkg::fetchBeat_t fetch,
	output logic pixel,
	output logic disEn,
	output logic cursor
);

	localparam int countWidth = $clog2(`CRTC_CHAR_PIXELS + 1);

	logic [`CRTC_DATA_WIDTH-1:0] shiftReg;
	logic [countWidth-1:0] remaining;

	// MSB first
	always_ff @(posedge CLK) begin
		if (charEn)
			shiftReg <= fetch.data;
		else
			shiftReg <= {shiftReg[`CRTC_DATA_WIDTH-2:0], 1'b0};
	end

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			disEn <= 1'b0;
			cursor <= 1'b0;
			remaining <= '0;
		end else if (charEn) begin
			disEn <= fetch.disEn;
			cursor <= fetch.cursor;
			remaining <= countWidth'(`CRTC_CHAR_PIXELS);
		end else if (remaining != '0) begin
			remaining <= remaining - 1'b1;
		end
	end

	// Blank once the character's pixels are used up
	assign pixel = disEn && (remaining != '0) && (shiftReg[`CRTC_DATA_WIDTH-1] ^ cursor);

endmodule

//--- design/videoSubsystem.sv
`include "crtc_settings.svh"

module videoSubsystem (
	input  logic CLK,
	input  logic nRESET,
	input  logic cs,
	input  logic rnw,
	input  logic a0,
	input  logic [`CRTC_DATA_WIDTH-1:0] dataIn,
	output logic [`CRTC_DATA_WIDTH-1:0] dataOut,
	input  logic charEn,
	input  logic memWrite,
	input  crtcPkg::memAdr_t memAdr,
	input  logic [`CRTC_DATA_WIDTH-1:0] memData,
	output logic hSync,
	output logic vSync,
	output logic disEn,
	output logic cursor,
	output crtcPkg::memAdr_t videoAdr,
	output crtcPkg::scanLine_t row,
	output logic pixel
);

	import crtcPkg::*;

	crtcConfig_t cfg;
	logic hRestart;
	logic vRestart;
	videoBeat_t beat;
	fetchBeat_t fetch;

	crtcRegisters uRegisters (
		.CLK(CLK),
		.nRESET(nRESET),
		.cs(cs),
		.rnw(rnw),
		.a0(a0),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.cfg(cfg),
		.hRestart(hRestart),
		.vRestart(vRestart)
	);

	crtcTiming uTiming (
		.CLK(CLK),
		.nRESET(nRESET),
		.charEn(charEn),
		.cfg(cfg),
		.hRestart(hRestart),
		.vRestart(vRestart),
		.beat(beat),
		.hSync(hSync),
		.vSync(vSync)
	);

	frameStore uFrameStore (
		.CLK(CLK),
		.charEn(charEn),
		.memWrite(memWrite),
		.memAdr(memAdr),
		.memData(memData),
		.beat(beat),
		.fetch(fetch)
	);

	pixelShifter uShifter (
		.CLK(CLK),
		.nRESET(nRESET),
		.charEn(charEn),
		.fetch(fetch),
		.pixel(pixel),
		.disEn(disEn),
		.cursor(cursor)
	);

	assign videoAdr = beat.adr;
	assign row = beat.row;

endmodule

//--- testbench/crtc_properties.sv
module crtcProperties (
	input  logic CLK,
	input  logic nRESET,
	input  logic charEn,
	input  crtcPkg::crtcConfig_t cfg,
	input  crtcPkg::charCount_t hCount,
	input  logic hSync,
	input  crtcPkg::hState_t hState,
	input  crtcPkg::vState_t vState
);

	import crtcPkg::*;

	// Forward through the line, or back to the start of a new one
	function automatic logic hLegal(input logic [1:0] prev, input logic [1:0] cur);
		return (cur == prev) || (cur == hDisplay) ||
			(prev == hDisplay && cur == hFront) ||
			(prev == hFront && (cur == hPulse || cur == hBack)) ||
			(prev == hPulse && cur == hBack);
	endfunction

	function automatic logic vLegal(input logic [1:0] prev, input logic [1:0] cur);
		return (cur == prev) || (cur == vDisplay) ||
			(prev == vDisplay && cur == vFront) ||
			(prev == vFront && (cur == vPulse || cur == vBack)) ||
			(prev == vPulse && cur == vBack);
	endfunction

	// Sync only after the last displayed character of the line
	syncOutsideDisplay: assert property (@(posedge CLK) disable iff (!nRESET)
		hSync |-> (hCount >= cfg.horzDisplayed))
		else $error("hSync high inside the displayed characters");

	hOrder: assert property (@(posedge CLK) disable iff (!nRESET)
		charEn |=> hLegal($past(hState), hState)) else $error("illegal horizontal step");

	vOrder: assert property (@(posedge CLK) disable iff (!nRESET)
		charEn |=> vLegal($past(vState), vState)) else $error("illegal vertical step");

endmodule

bind crtcTiming crtcProperties props0 (
	.CLK(CLK),
	.nRESET(nRESET),
	.charEn(charEn),
	.cfg(cfg),
	.hCount(hCount),
	.hSync(hSync),
	.hState(hState),
	.vState(vState)
);

//--- testbench/videoMonitor.sv
`include "crtc_settings.svh"

module videoMonitor (
	input  logic CLK,
	input  logic nRESET,
	input  logic charEn,
	input  logic cs,
	input  logic rnw,
	input  logic a0,
	input  logic [`CRTC_DATA_WIDTH-1:0] dataIn,
	input  logic [`CRTC_DATA_WIDTH-1:0] dataOut,
	input  logic memWrite,
	input  crtcPkg::memAdr_t memAdr,
	input  logic [`CRTC_DATA_WIDTH-1:0] memData,
	input  logic hSync,
	input  logic vSync,
	input  logic disEn,
	input  logic cursor,
	input  crtcPkg::memAdr_t videoAdr,
	input  crtcPkg::scanLine_t row,
	input  logic pixel,
	input  logic [15:0][7:0] regs,
	input  logic [5:0][15:0] expected,
	output int errors,
	output int frames
);

	import crtcPkg::*;

	logic [7:0] shadow [0:(1 << `CRTC_ADR_WIDTH)-1];
	logic [4:0] sel;
	logic readPending;
	logic [7:0] readWant;
	logic prevH;
	logic prevV;
	logic synced;
	logic hStarted;
	int vRises;
	int ch;
	int ln;
	int pipeCount;
	int hPeriod;
	int hHigh;
	int disChars;
	int vLines;
	int vHighLines;
	int disLines;
	int lineChars;
	int rowLines;
	int frameLines;
	int syncLine;
	int rowIdx;
	int scanIdx;
	logic [7:0] pixBits;
	logic [7:0] pipeByte [0:1];
	logic pipeDis [0:1];
	logic pipeCur [0:1];
	logic expDis;
	logic expCur;
	memAdr_t expAdr;

	task automatic mismatch(input string what, input int got, input int want);
		$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
		errors++;
	endtask

	task automatic compareCount(input string what, input int got, input int idx);
		if (got != int'(expected[idx]))
			mismatch(what, got, int'(expected[idx]));
	endtask

	// Copy of every byte the processor stores
	always @(posedge CLK) begin
		if (memWrite)
			shadow[memAdr] <= memData;
	end

	task checkCharacter();
		lineChars = int'(regs[0]) + 1;
		rowLines = int'(regs[9][4:0]) + 1;
		frameLines = (int'(regs[4][6:0]) + 1) * rowLines + int'(regs[5][4:0]);
		syncLine = int'(regs[7][6:0]) * rowLines;
		if (vSync && !prevV) begin
			vRises++;
			if (synced) begin
				if (ln != syncLine)
					mismatch("line at vSync rise", ln, syncLine);
				compareCount("lines per frame", vLines, 2);
				compareCount("vSync lines", vHighLines, 3);
				compareCount("displayed lines", disLines, 5);
				frames++;
			end else if (vRises == 2) begin
				// First character of the sync line
				synced = 1'b1;
				ch = 0;
				ln = syncLine;
				pipeCount = 0;
			end
			vLines = 0;
			vHighLines = 0;
			disLines = 0;
			hStarted = 1'b0;
			hHigh = 0;
			disChars = 0;
		end
		if (synced) begin
			if (hSync && !prevH) begin
				if (hStarted) begin
					compareCount("charEn per line", hPeriod, 0);
					if (disChars > 0) begin
						compareCount("displayed chars", disChars, 4);
						disLines++;
					end
				end
				hStarted = 1'b1;
				hPeriod = 0;
				disChars = 0;
				vLines++;
				if (vSync)
					vHighLines++;
			end
			if (hSync) begin
				hHigh++;
			end else begin
				if (prevH && hStarted)
					compareCount("hSync width", hHigh, 1);
				hHigh = 0;
			end
			hPeriod++;
			if (disEn)
				disChars++;

			// Expected beat from the position in the frame
			rowIdx = ln / rowLines;
			scanIdx = ln % rowLines;
			expDis = (ch < int'(regs[1])) && (ln < int'(regs[6][6:0]) * rowLines);
			expAdr = memAdr_t'(int'({regs[12][5:0], regs[13]}) + rowIdx * int'(regs[1]) + ch);
			expCur = expDis && (regs[10][6:5] == 2'd0) && (scanIdx >= int'(regs[10][4:0])) &&
				(scanIdx <= int'(regs[11][4:0])) && (expAdr == {regs[14][5:0], regs[15]});
			if (expDis) begin
				if (videoAdr != expAdr)
					mismatch("videoAdr", int'(videoAdr), int'(expAdr));
				if (int'(row) != scanIdx)
					mismatch("row", int'(row), scanIdx);
			end
			// Pixels of the beat two characters back
			if (pipeCount == 2) begin
				if (disEn != pipeDis[1])
					mismatch("disEn", int'(disEn), int'(pipeDis[1]));
				if (cursor != pipeCur[1])
					mismatch("cursor", int'(cursor), int'(pipeCur[1]));
				if (pixBits != pipeByte[1])
					mismatch("pixels", int'(pixBits), int'(pipeByte[1]));
			end else begin
				pipeCount++;
			end
			pipeByte[1] = pipeByte[0];
			pipeDis[1] = pipeDis[0];
			pipeCur[1] = pipeCur[0];
			pipeByte[0] = expDis ? (shadow[expAdr] ^ {8{expCur}}) : 8'h00;
			pipeDis[0] = expDis;
			pipeCur[0] = expCur;
			ch++;
			if (ch == lineChars) begin
				ch = 0;
				ln++;
				if (ln == frameLines)
					ln = 0;
			end
		end
		prevH = hSync;
		prevV = vSync;
	endtask

	always @(posedge CLK) begin
		if (!nRESET) begin
			errors = 0;
			frames = 0;
			sel = '0;
			readPending = 1'b0;
			synced = 1'b0;
			vRises = 0;
			prevH = 1'b0;
			prevV = 1'b0;
			pixBits = '0;
		end else begin
			// Readback is valid one clock after the strobe
			if (readPending && dataOut != readWant)
				mismatch("cursor readback", int'(dataOut), int'(readWant));
			readPending = cs && rnw;
			readWant = sel[0] ? regs[15] : {2'b00, regs[14][5:0]};
			if (cs && !rnw && !a0)
				sel = dataIn[4:0];
			pixBits = {pixBits[6:0], pixel};
			if (charEn)
				checkCharacter();
		end
	end

endmodule

//--- testbench/tbVideo.sv
`include "crtc_settings.svh"

module tbVideo;

	import crtcPkg::*;

	logic CLK;
	logic nRESET;
	logic cs;
	logic rnw;
	logic a0;
	logic charEn;
	logic memWrite;
	logic [`CRTC_DATA_WIDTH-1:0] dataIn;
	logic [`CRTC_DATA_WIDTH-1:0] dataOut;
	logic [`CRTC_DATA_WIDTH-1:0] memData;
	memAdr_t memAdr;
	memAdr_t videoAdr;
	scanLine_t row;
	logic hSync;
	logic vSync;
	logic disEn;
	logic cursor;
	logic pixel;
	logic [2:0] charPhase;
	logic [31:0] lfsr;
	logic [15:0][7:0] regs;
	logic [5:0][15:0] expected;
	logic [31:0] trace [0:63];
	int errors;
	int frames;
	int otherErrors;
	int step;
	longint limit;

	videoSubsystem dut0 (.*);

	videoMonitor monitor0 (.*);

	always #20 CLK = ~CLK;

	// Character strobe on every eighth clock
	always @(posedge CLK) begin
		charPhase <= charPhase + 1'b1;
		charEn <= (charPhase == 3'd7);
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randomByte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsrNext(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic busWrite(input logic isData, input logic [7:0] value);
		@(posedge CLK);
		cs <= 1'b1;
		rnw <= 1'b0;
		a0 <= isData;
		dataIn <= value;
		@(posedge CLK);
		cs <= 1'b0;
	endtask

	task automatic writeRegister(input logic [4:0] num, input logic [7:0] value);
		busWrite(1'b0, {3'b000, num});
		busWrite(1'b1, value);
		regs[num[3:0]] <= value;
	endtask

	task automatic readRegister(input logic [4:0] num);
		busWrite(1'b0, {3'b000, num});
		@(posedge CLK);
		cs <= 1'b1;
		rnw <= 1'b1;
		@(posedge CLK);
		cs <= 1'b0;
		rnw <= 1'b0;
		@(posedge CLK);
	endtask

	task automatic fillMemory(input int count);
		logic [7:0] b;
		for (int i = 0; i < count; i++) begin
			randomByte(b);
			@(posedge CLK);
			memWrite <= 1'b1;
			memAdr <= memAdr_t'(i);
			memData <= b;
		end
		@(posedge CLK);
		memWrite <= 1'b0;
	endtask

	// Frame lengths from the trace, one spare frame per wait
	function automatic longint runLimit();
		logic [7:0] r [0:15];
		longint total;
		longint frameChars;
		total = 0;
		for (int i = 0; i < 16; i++)
			r[i] = '0;
		for (int i = 0; i < 64; i++) begin
			if (trace[i][31:24] == 8'h00)
				break;
			if (trace[i][31:24] == 8'h01)
				r[trace[i][19:16]] = trace[i][7:0];
			if (trace[i][31:24] == 8'h05) begin
				frameChars = longint'(r[0] + 1) * (longint'(r[4][6:0] + 1) *
					longint'(r[9][4:0] + 1) + longint'(r[5][4:0]));
				total += longint'(trace[i][15:0] + 1) * frameChars;
			end
		end
		return total * 320 + 200000;
	endfunction

	task automatic watchdog(input longint timeLimit);
		#(timeLimit);
		$display("Timeout: the run did not end within %0d time units", timeLimit);
		$display("TEST FAILED");
		$finish;
	endtask

	initial begin
		CLK = 1'b0;
		nRESET = 1'b0;
		cs = 1'b0;
		rnw = 1'b0;
		a0 = 1'b0;
		dataIn = '0;
		charEn = 1'b0;
		memWrite = 1'b0;
		memAdr = '0;
		memData = '0;
		charPhase = '0;
		lfsr = 32'h10da_f9e1;
		regs = '0;
		expected = '0;
		otherErrors = 0;
		$readmemh("testbench/video_trace.txt", trace);
		limit = runLimit();
		fork
			watchdog(limit);
		join_none
		repeat (4) @(posedge CLK);
		nRESET <= 1'b1;
		step = 0;
		while (step < 64 && trace[step][31:24] != 8'h00) begin
			case (trace[step][31:24])
				8'h01: writeRegister(trace[step][20:16], trace[step][7:0]);
				8'h02: readRegister(trace[step][20:16]);
				8'h03: fillMemory(int'(trace[step][15:0]));
				8'h04: expected[trace[step][18:16]] = trace[step][15:0];
				8'h05: repeat (int'(trace[step][15:0])) @(posedge vSync);
				default: begin
					$display("Unknown trace code at entry %0d", step);
					otherErrors++;
				end
			endcase
			step++;
		end
		repeat (2) @(posedge CLK);
		if (frames == 0) begin
			$display("No complete frame was measured");
			otherErrors++;
		end
		$display("Done: %0d check errors, %0d other errors, %0d frames measured",
			errors, otherErrors, frames);
		if (errors == 0 && otherErrors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- testbench/video_trace.txt
// Columns: code(8) index(8) value(16); 01 write reg, 02 read reg, 03 fill bytes,
// 04 expected measurement, 05 wait vSync rises, 00 end
04000014
04010003
0402001A
04030002
0404000A
0405000C
01000013
0101000A
0102000D
01030023
01040005
01050002
01060003
01070004
01090003
010A0001
010B0002
010C0000
010D0010
010E00C0
010F0015
020E0000
020F0000
03000080
05000004
010A0021
05000003
00000000

//--- sim.f
+incdir+include
design/crtcPkg.sv
design/crtcRegisters.sv
design/crtcTiming.sv
design/frameStore.sv
design/pixelShifter.sv
design/videoSubsystem.sv
testbench/crtc_properties.sv
testbench/videoMonitor.sv
testbench/tbVideo.sv

//--- Makefile
LOG = sim.log

sim:
	verilator --binary --assert -Wno-fatal --top-module tbVideo -f sim.f -o simv
	./obj_dir/simv > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
